//--- verilog/mips_isa_pkg.sv
// instruction-set definitions for the mips pipeline, imported by the RTL and the testbench encoder
package mips_isa_pkg;

   // data word and the fields cut from an instruction
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;

   // word address on the instruction and data ports, byte offset dropped
   typedef logic [29:0] waddr_t;

   // program counter after reset, start of the text segment
   localparam word_t text_start_default = 32'h0040_0000;

   // primary opcodes
   // special selects the register-register group through funct
   localparam opcode_t op_special = 6'h00;
   localparam opcode_t op_addi    = 6'h08;
   localparam opcode_t op_addiu   = 6'h09;
   localparam opcode_t op_slti    = 6'h0a;
   localparam opcode_t op_sltiu   = 6'h0b;
   localparam opcode_t op_andi    = 6'h0c;
   localparam opcode_t op_ori     = 6'h0d;
   localparam opcode_t op_xori    = 6'h0e;
   localparam opcode_t op_lui     = 6'h0f;
   localparam opcode_t op_lw      = 6'h23;
   localparam opcode_t op_sw      = 6'h2b;

   // function codes under op_special
   // constant shifts take shamt, variable shifts take rs
   localparam funct_t fn_sll  = 6'h00;
   localparam funct_t fn_srl  = 6'h02;
   localparam funct_t fn_sra  = 6'h03;
   localparam funct_t fn_sllv = 6'h04;
   localparam funct_t fn_srlv = 6'h06;
   localparam funct_t fn_srav = 6'h07;
   localparam funct_t fn_add  = 6'h20;
   localparam funct_t fn_addu = 6'h21;
   localparam funct_t fn_sub  = 6'h22;
   localparam funct_t fn_subu = 6'h23;
   localparam funct_t fn_and  = 6'h24;
   localparam funct_t fn_or   = 6'h25;
   localparam funct_t fn_xor  = 6'h26;
   localparam funct_t fn_nor  = 6'h27;
   localparam funct_t fn_slt  = 6'h2a;
   localparam funct_t fn_sltu = 6'h2b;

endpackage

//--- verilog/mips_pipe_pkg.sv
// pipeline definitions shared by the stage modules: alu codes, control bundle, stage registers
package mips_pipe_pkg;

   import mips_isa_pkg::*;

   // alu operation selected in decode, carried to execute
   typedef logic [3:0] alu_sel_t;

   localparam alu_sel_t alu_add  = 4'd0;
   localparam alu_sel_t alu_sub  = 4'd1;
   localparam alu_sel_t alu_and  = 4'd2;
   localparam alu_sel_t alu_or   = 4'd3;
   localparam alu_sel_t alu_xor  = 4'd4;
   localparam alu_sel_t alu_nor  = 4'd5;
   localparam alu_sel_t alu_slt  = 4'd6;
   localparam alu_sel_t alu_sltu = 4'd7;
   localparam alu_sel_t alu_sll  = 4'd8;
   localparam alu_sel_t alu_srl  = 4'd9;
   localparam alu_sel_t alu_sra  = 4'd10;
   localparam alu_sel_t alu_sllv = 4'd11;
   localparam alu_sel_t alu_srlv = 4'd12;
   localparam alu_sel_t alu_srav = 4'd13;
   // passes the second operand, used by lui
   localparam alu_sel_t alu_lui  = 4'd14;

   // all-zero value is the bubble
   typedef struct packed {
      logic     reg_we;
      logic     mem_we;
      logic     mem_to_reg;
      logic     alu_src_imm;
      alu_sel_t alu_sel;
   } ctrl_t;

   // stage registers
   typedef struct packed {
      ctrl_t    ctrl;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
      reg_idx_t dest;
   } id_ex_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    alu_out;
      word_t    rt_val;
      reg_idx_t dest;
   } ex_mem_t;

   typedef struct packed {
      logic     reg_we;
      word_t    value;
      reg_idx_t dest;
   } mem_wb_t;

   // writeback as seen by the register file and the hazard unit
   typedef struct packed {
      logic     we;
      reg_idx_t dest;
      word_t    value;
   } wb_t;

   // remaining stall cycles after a hazard is seen
   typedef logic [1:0] stall_cnt_t;

endpackage

//--- verilog/mips_fetch.sv
// fetch stage, keeps the program counter and drives the instruction address of the core
module mips_fetch
   import mips_isa_pkg::*;
#(
   parameter word_t text_start = text_start_default
) (
   input  logic   clk,
   input  logic   rst_b,
   input  logic   stall,
   output waddr_t inst_addr
);

   // pc is held as a word address, the byte offset is always zero
   localparam waddr_t start_word = text_start[31:2];

   waddr_t pc_q;

   // one word per cycle
   // hazard stall freezes the pc so the stalled instruction is fetched again
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc_q <= start_word;
      end else if (!stall) begin
         pc_q <= pc_q + 30'd1;
      end
   end

   // memory answers in the same cycle
   assign inst_addr = pc_q;

endmodule

//--- verilog/mips_regfile.sv
// general purpose register file for decode, two read ports and the writeback port
module mips_regfile
   import mips_isa_pkg::*, mips_pipe_pkg::*;
(
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t rs,
   input  reg_idx_t rt,
   input  wb_t      wb,
   output word_t    rs_data,
   output word_t    rt_data
);

   // r0 has no storage
   word_t regs [31:1];

   // r0 reads zero, a write in this cycle is passed straight to the reader
   function automatic word_t read_port(input reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end else if (wb.we && wb.dest == idx) begin
         return wb.value;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.we && wb.dest != '0) begin
         regs[wb.dest] <= wb.value;
      end
   end

   // reads follow the storage and the writeback as well as the index
   always_comb begin
      rs_data = read_port(rs);
      rt_data = read_port(rt);
   end

endmodule

//--- verilog/mips_decode.sv
// decode stage: if/id register, control decode, register read and the id/ex register
module mips_decode
   import mips_isa_pkg::*, mips_pipe_pkg::*;
(
   input  logic     clk,
   input  logic     rst_b,
   input  logic     stall,
   input  word_t    inst,
   input  wb_t      wb,
   output id_ex_t   id_ex,
   output reg_idx_t rs,
   output reg_idx_t rt
);

   word_t       ir_q;
   opcode_t     opcode;
   funct_t      funct;
   reg_idx_t    rd;
   logic [15:0] imm16;
   word_t       imm;
   word_t       rs_data;
   word_t       rt_data;
   ctrl_t       ctrl_d;
   reg_idx_t    dest;
   logic        op_known;

   // id/ex registers, control resets, operands do not
   ctrl_t       ctrl_q;
   word_t       rs_q;
   word_t       rt_q;
   word_t       imm_q;
   reg_idx_t    dest_q;

   // instruction register, zero after reset decodes as sll r0 (no-op)
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ir_q <= '0;
      end else if (!stall) begin
         ir_q <= inst;
      end
   end

   assign opcode = ir_q[31:26];
   assign rs     = ir_q[25:21];
   assign rt     = ir_q[20:16];
   assign rd     = ir_q[15:11];
   assign funct  = ir_q[5:0];
   assign imm16  = ir_q[15:0];

   mips_regfile i_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs      (rs),
      .rt      (rt),
      .wb      (wb),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   always_comb begin
      ctrl_d   = '0;
      dest     = rt;
      op_known = 1'b1;
      case (opcode)
         op_special: begin
            // r-type writes rd, unknown funct leaves no write
            dest          = rd;
            ctrl_d.reg_we = 1'b1;
            case (funct)
               fn_sll:          ctrl_d.alu_sel = alu_sll;
               fn_srl:          ctrl_d.alu_sel = alu_srl;
               fn_sra:          ctrl_d.alu_sel = alu_sra;
               fn_sllv:         ctrl_d.alu_sel = alu_sllv;
               fn_srlv:         ctrl_d.alu_sel = alu_srlv;
               fn_srav:         ctrl_d.alu_sel = alu_srav;
               fn_add, fn_addu: ctrl_d.alu_sel = alu_add;
               fn_sub, fn_subu: ctrl_d.alu_sel = alu_sub;
               fn_and:          ctrl_d.alu_sel = alu_and;
               fn_or:           ctrl_d.alu_sel = alu_or;
               fn_xor:          ctrl_d.alu_sel = alu_xor;
               fn_nor:          ctrl_d.alu_sel = alu_nor;
               fn_slt:          ctrl_d.alu_sel = alu_slt;
               fn_sltu:         ctrl_d.alu_sel = alu_sltu;
               default:         ctrl_d.reg_we  = 1'b0;
            endcase
         end
         op_addi, op_addiu: ctrl_d.alu_sel = alu_add;
         op_slti:           ctrl_d.alu_sel = alu_slt;
         op_sltiu:          ctrl_d.alu_sel = alu_sltu;
         op_andi:           ctrl_d.alu_sel = alu_and;
         op_ori:            ctrl_d.alu_sel = alu_or;
         op_xori:           ctrl_d.alu_sel = alu_xor;
         op_lui:            ctrl_d.alu_sel = alu_lui;
         // address is rs plus offset
         op_lw:             ctrl_d.mem_to_reg = 1'b1;
         op_sw:             ctrl_d.mem_we = 1'b1;
         default:           op_known = 1'b0;
      endcase
      // i-type group takes the immediate and writes rt, except sw
      if (opcode != op_special) begin
         ctrl_d.alu_src_imm = op_known;
         ctrl_d.reg_we      = op_known && (opcode != op_sw);
      end
   end

   // logical ops zero-extend, lui moves to the upper half
   // shamt of r-type sits in bits 10:6 of the sign-extended form
   always_comb begin
      case (opcode)
         op_andi, op_ori, op_xori: imm = {16'h0000, imm16};
         op_lui:                   imm = {imm16, 16'h0000};
         default:                  imm = {{16{imm16[15]}}, imm16};
      endcase
   end

   // bubble while stalled, the held instruction issues later
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ctrl_q <= '0;
      end else begin
         ctrl_q <= stall ? '0 : ctrl_d;
      end
   end

   always_ff @(posedge clk) begin
      rs_q   <= rs_data;
      rt_q   <= rt_data;
      imm_q  <= imm;
      dest_q <= dest;
   end

   assign id_ex = '{ctrl: ctrl_q, rs_val: rs_q, rt_val: rt_q, imm: imm_q, dest: dest_q};

endmodule

//--- verilog/mips_hazard.sv
// read-after-write hazard detection, freezes fetch and decode with a cycle countdown
module mips_hazard
   import mips_isa_pkg::*, mips_pipe_pkg::*;
(
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t rs,
   input  reg_idx_t rt,
   input  id_ex_t   id_ex,
   input  ex_mem_t  ex_mem,
   input  wb_t      wb,
   output logic     stall
);

   stall_cnt_t cnt_q;
   stall_cnt_t cnt_load;
   logic       hit_ex;
   logic       hit_mem;
   logic       hit_wb;
   logic       detect;

   // r0 never causes a wait
   function automatic logic reads(input reg_idx_t dest);
      return (rs != '0 && rs == dest) || (rt != '0 && rt == dest);
   endfunction

   // only register writers count, stores and bubbles do not
   always_comb begin
      hit_ex  = id_ex.ctrl.reg_we && reads(id_ex.dest);
      hit_mem = ex_mem.ctrl.reg_we && reads(ex_mem.dest);
      hit_wb  = wb.we && reads(wb.dest);
   end

   // nearest writer sets the length, no new check while counting
   assign detect   = (cnt_q == '0) && (hit_ex || hit_mem || hit_wb);
   assign cnt_load = hit_ex ? 2'd3 : (hit_mem ? 2'd2 : 2'd1);

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         cnt_q <= '0;
      end else if (detect) begin
         cnt_q <= cnt_load;
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 2'd1;
      end
   end

   assign stall = detect || (cnt_q != '0);

endmodule

//--- verilog/mips_execute.sv
// execute stage, alu with operand select and the ex/mem register
module mips_execute
   import mips_isa_pkg::*, mips_pipe_pkg::*;
(
   input  logic    clk,
   input  logic    rst_b,
   input  id_ex_t  id_ex,
   output ex_mem_t ex_mem
);

   word_t      op_a;
   word_t      op_b;
   logic [4:0] shamt;
   logic [4:0] vshamt;
   word_t      alu_out;

   // ex/mem registers
   ctrl_t      ctrl_q;
   word_t      alu_q;
   word_t      rt_q;
   reg_idx_t   dest_q;

   assign op_a   = id_ex.rs_val;
   assign op_b   = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rt_val;
   // constant amount from the shamt field, variable amount from rs
   assign shamt  = id_ex.imm[10:6];
   assign vshamt = id_ex.rs_val[4:0];

   // shifts always act on rt
   always_comb begin
      case (id_ex.ctrl.alu_sel)
         alu_add:  alu_out = op_a + op_b;
         alu_sub:  alu_out = op_a - op_b;
         alu_and:  alu_out = op_a & op_b;
         alu_or:   alu_out = op_a | op_b;
         alu_xor:  alu_out = op_a ^ op_b;
         alu_nor:  alu_out = ~(op_a | op_b);
         alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
         alu_sltu: alu_out = {31'b0, op_a < op_b};
         alu_sll:  alu_out = id_ex.rt_val << shamt;
         alu_srl:  alu_out = id_ex.rt_val >> shamt;
         alu_sra:  alu_out = word_t'($signed(id_ex.rt_val) >>> shamt);
         alu_sllv: alu_out = id_ex.rt_val << vshamt;
         alu_srlv: alu_out = id_ex.rt_val >> vshamt;
         alu_srav: alu_out = word_t'($signed(id_ex.rt_val) >>> vshamt);
         alu_lui:  alu_out = op_b;
         default:  alu_out = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ctrl_q <= '0;
      end else begin
         ctrl_q <= id_ex.ctrl;
      end
   end

   // rt travels on as store data
   always_ff @(posedge clk) begin
      alu_q  <= alu_out;
      rt_q   <= id_ex.rt_val;
      dest_q <= id_ex.dest;
   end

   assign ex_mem = '{ctrl: ctrl_q, alu_out: alu_q, rt_val: rt_q, dest: dest_q};

endmodule

//--- verilog/mips_memory.sv
// memory stage, drives the data port and holds the mem/wb register for writeback
module mips_memory
   import mips_isa_pkg::*, mips_pipe_pkg::*;
(
   input  logic       clk,
   input  logic       rst_b,
   input  ex_mem_t    ex_mem,
   output waddr_t     mem_addr,
   output word_t      mem_data_in,
   output logic [3:0] mem_write_en,
   input  word_t      mem_data_out,
   output wb_t        wb
);

   mem_wb_t  mem_wb_d;
   logic     reg_we_q;
   word_t    value_q;
   reg_idx_t dest_q;

   // word accesses only, alu result is the byte address
   assign mem_addr     = ex_mem.alu_out[31:2];
   assign mem_data_in  = ex_mem.rt_val;
   assign mem_write_en = {4{ex_mem.ctrl.mem_we}};

   // load data arrives in this cycle
   assign mem_wb_d.reg_we = ex_mem.ctrl.reg_we;
   assign mem_wb_d.value  = ex_mem.ctrl.mem_to_reg ? mem_data_out : ex_mem.alu_out;
   assign mem_wb_d.dest   = ex_mem.dest;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         reg_we_q <= 1'b0;
      end else begin
         reg_we_q <= mem_wb_d.reg_we;
      end
   end

   always_ff @(posedge clk) begin
      value_q <= mem_wb_d.value;
      dest_q  <= mem_wb_d.dest;
   end

   // writeback goes to the register file and the hazard unit
   assign wb = '{we: reg_we_q, dest: dest_q, value: value_q};

endmodule

//--- verilog/mips_core.sv
// five-stage mips integer core, the top level seen by the memories and the testbench
module mips_core
   import mips_isa_pkg::*, mips_pipe_pkg::*;
#(
   parameter word_t text_start = text_start_default
) (
   input  logic       clk,
   input  logic       rst_b,
   output waddr_t     inst_addr,
   input  word_t      inst,
   output waddr_t     mem_addr,
   output word_t      mem_data_in,
   output logic [3:0] mem_write_en,
   input  word_t      mem_data_out
);

   // stage to stage
   id_ex_t   id_ex;
   ex_mem_t  ex_mem;
   wb_t      wb;
   // hazard loop
   reg_idx_t rs;
   reg_idx_t rt;
   logic     stall;

   mips_fetch #(
      .text_start (text_start)
   ) i_fetch (
      .clk       (clk),
      .rst_b     (rst_b),
      .stall     (stall),
      .inst_addr (inst_addr)
   );

   mips_decode i_decode (
      .clk   (clk),
      .rst_b (rst_b),
      .stall (stall),
      .inst  (inst),
      .wb    (wb),
      .id_ex (id_ex),
      .rs    (rs),
      .rt    (rt)
   );

   mips_hazard i_hazard (
      .clk    (clk),
      .rst_b  (rst_b),
      .rs     (rs),
      .rt     (rt),
      .id_ex  (id_ex),
      .ex_mem (ex_mem),
      .wb     (wb),
      .stall  (stall)
   );

   mips_execute i_execute (
      .clk    (clk),
      .rst_b  (rst_b),
      .id_ex  (id_ex),
      .ex_mem (ex_mem)
   );

   mips_memory i_memory (
      .clk          (clk),
      .rst_b        (rst_b),
      .ex_mem       (ex_mem),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .mem_data_out (mem_data_out),
      .wb           (wb)
   );

endmodule

//--- bench/mips_ref_model.svh
// random program generator and instruction-level model of the core, included in the testbench module
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// program image and the results the model expects
word_t  prog [prog_len];
word_t  model_regs [32];
word_t  model_mem [dmem_words];
waddr_t exp_addr [$];
word_t  exp_data [$];
word_t  lcg_state;

// functions the generator picks from
localparam funct_t r_functs [16] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or,
   fn_xor, fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
localparam opcode_t i_ops [8] = '{op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori,
   op_xori, op_lui};

function automatic word_t lcg_next();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return lcg_state;
endfunction

// upper half only, the low bits of an lcg repeat quickly
function automatic int unsigned rand_below(input int unsigned n);
   word_t r;
   r = lcg_next();
   return {16'h0000, r[31:16]} % n;
endfunction

// initial memory contents, every address bit matters
function automatic word_t fill_word(input int unsigned idx);
   return (word_t'(idx) * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
endfunction

function automatic word_t enc_r(input funct_t fn, input reg_idx_t rs, input reg_idx_t rt,
                                input reg_idx_t rd, input logic [4:0] sh);
   return {op_special, rs, rt, rd, sh, fn};
endfunction

function automatic word_t enc_i(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
                                input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

// destinations from r1..r7, sources take r0 as well
function automatic reg_idx_t pick_dst();
   return reg_idx_t'(1 + rand_below(7));
endfunction

function automatic reg_idx_t pick_src();
   return reg_idx_t'(rand_below(8));
endfunction

// byte offset into a 16-word window so loads often find earlier stores
function automatic logic [15:0] mem_offset();
   logic [15:0] off;
   off = 16'(rand_below(16));
   return off << 2;
endfunction

function automatic void gen_program();
   int unsigned kind;
   int unsigned n;
   word_t       rnd;
   reg_idx_t    s;
   reg_idx_t    t;
   reg_idx_t    d;
   funct_t      fn;
   opcode_t     op;
   lcg_state = 32'd52;
   n = 0;
   // full 32-bit start values, each ori reads the lui just before it
   for (int r = 1; r < 8; r++) begin
      rnd = lcg_next();
      prog[n] = enc_i(op_lui, '0, reg_idx_t'(r), rnd[31:16]);
      prog[n + 1] = enc_i(op_ori, reg_idx_t'(r), reg_idx_t'(r), rnd[15:0]);
      n += 2;
   end
   while (n < prog_len - 7) begin
      kind = rand_below(16);
      rnd  = lcg_next();
      s    = pick_src();
      t    = pick_src();
      d    = pick_dst();
      if (kind < 6) begin
         fn = r_functs[rand_below(16)];
         // constant shifts leave rs empty, as an assembler would
         if (fn == fn_sll || fn == fn_srl || fn == fn_sra) s = '0;
         prog[n] = enc_r(fn, s, t, d, rnd[10:6]);
      end else if (kind < 10) begin
         op = i_ops[rand_below(8)];
         if (op == op_lui) s = '0;
         prog[n] = enc_i(op, s, d, rnd[15:0]);
      end else if (kind < 12) begin
         prog[n] = enc_i(op_lw, '0, d, mem_offset());
      end else if (kind < 15) begin
         prog[n] = enc_i(op_sw, '0, t, mem_offset());
      end else begin
         // write to r0, must be thrown away
         prog[n] = enc_i(op_addiu, s, '0, rnd[15:0]);
      end
      n++;
   end
   // closing stores expose r1..r7 at words 241..247
   for (int r = 1; r < 8; r++) begin
      prog[n] = enc_i(op_sw, '0, reg_idx_t'(r), 16'(960 + 4 * r));
      n++;
   end
endfunction

// executes the program once in order, collects the store sequence
function automatic void run_model();
   word_t    w;
   word_t    a;
   word_t    b;
   word_t    se;
   word_t    ze;
   word_t    addr;
   word_t    res;
   reg_idx_t dst;
   logic     wr;
   for (int i = 0; i < 32; i++) model_regs[i] = '0;
   for (int i = 0; i < dmem_words; i++) model_mem[i] = fill_word(i);
   exp_addr.delete();
   exp_data.delete();
   for (int pc = 0; pc < prog_len; pc++) begin
      w    = prog[pc];
      a    = model_regs[w[25:21]];
      b    = model_regs[w[20:16]];
      se   = {{16{w[15]}}, w[15:0]};
      ze   = {16'h0000, w[15:0]};
      addr = a + se;
      res  = '0;
      wr   = 1'b1;
      dst  = w[20:16];
      case (w[31:26])
         op_special: begin
            dst = w[15:11];
            case (w[5:0])
               fn_add, fn_addu: res = a + b;
               fn_sub, fn_subu: res = a - b;
               fn_and:  res = a & b;
               fn_or:   res = a | b;
               fn_xor:  res = a ^ b;
               fn_nor:  res = ~(a | b);
               fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               fn_sltu: res = (a < b) ? 32'd1 : 32'd0;
               fn_sll:  res = b << w[10:6];
               fn_srl:  res = b >> w[10:6];
               fn_sra:  res = word_t'($signed(b) >>> w[10:6]);
               fn_sllv: res = b << a[4:0];
               fn_srlv: res = b >> a[4:0];
               fn_srav: res = word_t'($signed(b) >>> a[4:0]);
               default: wr = 1'b0;
            endcase
         end
         op_addi, op_addiu: res = a + se;
         // sltiu compares against the sign-extended immediate, unsigned
         op_slti:  res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
         op_sltiu: res = (a < se) ? 32'd1 : 32'd0;
         op_andi:  res = a & ze;
         op_ori:   res = a | ze;
         op_xori:  res = a ^ ze;
         op_lui:   res = {w[15:0], 16'h0000};
         op_lw:    res = model_mem[addr[9:2]];
         op_sw: begin
            wr = 1'b0;
            model_mem[addr[9:2]] = b;
            exp_addr.push_back(addr[31:2]);
            exp_data.push_back(b);
         end
         default: wr = 1'b0;
      endcase
      // r0 stays zero
      if (wr && dst != '0) model_regs[dst] = res;
   end
endfunction

`endif

//--- bench/mips_core_tb.sv
// testbench for the mips core: random program, combinational memories, store and memory checks
module mips_core_tb
   import mips_isa_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int     prog_len       = 120;
   localparam int     dmem_words     = 256;
   // budget of four cycles per instruction, stalls included
   localparam int     timeout_cycles = 4 * (prog_len + 10);
   localparam waddr_t text_base_w    = text_start_default[31:2];

   logic       clk          = 1'b0;
   logic       rst_b        = 1'b0;
   word_t      inst         = '0;
   word_t      mem_data_out = '0;
   waddr_t     inst_addr;
   waddr_t     mem_addr;
   word_t      mem_data_in;
   logic [3:0] mem_write_en;

   word_t      dmem [dmem_words];
   // store seen at the falling edge, committed at the next rising edge
   logic       pend_we = 1'b0;
   waddr_t     pend_addr;
   word_t      pend_data;
   int         store_idx = 0;
   int         exp_count = 0;
   int         error_cnt = 0;
   int         cycle_cnt = 0;

   `include "mips_ref_model.svh"

   mips_core #(
      .text_start (text_start_default)
   ) i_dut (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .mem_data_out (mem_data_out)
   );

   always #50 clk = ~clk;

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         error_cnt++;
         $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input waddr_t got, input waddr_t exp);
      if (got !== exp) begin
         error_cnt++;
         $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_write_en(input string name, input logic [3:0] got,
                                 input logic [3:0] exp);
      if (got !== exp) begin
         error_cnt++;
         $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // past the program the fetch sees zero, a no-op
   function automatic word_t fetch_word(input waddr_t a);
      waddr_t off;
      off = a - text_base_w;
      if (off < waddr_t'(prog_len)) return prog[int'(off)];
      return '0;
   endfunction

   function automatic word_t read_data(input waddr_t a);
      if (a < waddr_t'(dmem_words)) return dmem[a[7:0]];
      return '0;
   endfunction

   // stores checked in order, memory read ports driven
   always @(negedge clk) begin
      pend_we = 1'b0;
      if (rst_b && mem_write_en != 4'h0) begin
         check_write_en("mem_write_en", mem_write_en, 4'hf);
         if (store_idx < exp_count) begin
            check_addr("mem_addr", mem_addr, exp_addr[store_idx]);
            check_word("mem_data_in", mem_data_in, exp_data[store_idx]);
         end else begin
            error_cnt++;
            $display("ERROR t=%0t store %0d is one more than the model made", $time,
                     store_idx + 1);
         end
         store_idx++;
         pend_we   = (mem_write_en == 4'hf);
         pend_addr = mem_addr;
         pend_data = mem_data_in;
      end
      inst         = fetch_word(inst_addr);
      mem_data_out = read_data(mem_addr);
   end

   // memory gets its fill pattern while reset is held
   always @(posedge clk) begin
      if (!rst_b) begin
         for (int i = 0; i < dmem_words; i++) dmem[i] = fill_word(i);
      end else if (pend_we) begin
         dmem[pend_addr[7:0]] = pend_data;
      end
      cycle_cnt++;
   end

   initial begin
      wait (cycle_cnt >= timeout_cycles);
      $display("timeout after %0d cycles, %0d of %0d stores seen", cycle_cnt, store_idx,
               exp_count);
      $display("errors: %0d, stores: %0d of %0d", error_cnt + 1, store_idx, exp_count);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      gen_program();
      run_model();
      exp_count = exp_addr.size();
      // pc and store enable inside reset
      @(negedge clk);
      check_addr("inst_addr", inst_addr, text_base_w);
      check_write_en("mem_write_en", mem_write_en, 4'h0);
      @(negedge clk);
      rst_b = 1'b1;
      wait (store_idx >= exp_count);
      // the last store leaves memory on the next edge, a duplicate would follow within four
      repeat (4) @(negedge clk);
      if (store_idx != exp_count) begin
         error_cnt++;
         $display("ERROR store count is %0d, the model made %0d", store_idx, exp_count);
      end
      for (int i = 0; i < dmem_words; i++) begin
         check_word($sformatf("dmem[%0d]", i), dmem[i], model_mem[i]);
      end
      $display("errors: %0d, stores: %0d of %0d", error_cnt, store_idx, exp_count);
      if (error_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- mips_pipe.f
+incdir+bench
verilog/mips_isa_pkg.sv
verilog/mips_pipe_pkg.sv
verilog/mips_fetch.sv
verilog/mips_regfile.sv
verilog/mips_decode.sv
verilog/mips_hazard.sv
verilog/mips_execute.sv
verilog/mips_memory.sv
verilog/mips_core.sv
bench/mips_core_tb.sv

//--- Makefile
# tool, flags, top level and file list
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := mips_core_tb
FILELIST  := mips_pipe.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
